// ==== hdl/accel_pkg.sv ====
`default_nettype none

package accel_pkg;

  // ------------------------------
  // Register widths
  // ------------------------------
  localparam int MAP_CC_DATA_SZ = 7;
  localparam int GPIO_SZ        = 2;
  localparam int PAGEREG_SZ     = 4;

  // Low address bits selecting a register inside the register bank
  localparam logic [1:0] REG_SEL_MAP       = 2'd3;
  localparam logic [1:0] REG_SEL_GPIO_DATA = 2'd1;
  localparam logic [1:0] REG_SEL_GPIO_DIR  = 2'd0;

  // Top two bits of the effective bank
  localparam logic [1:0] REG_BANK_TAG = 2'b10;
  localparam logic [1:0] RAM_BANK_TAG = 2'b11;

  // ------------------------------
  // Host memory map constants
  // ------------------------------
  localparam logic [15:0] PAGED_ROM_SEL_ADR = 16'hFE30;
  localparam logic [3:0]  BASIC_ROM_SLOT    = 4'hF;
  localparam logic [7:0]  REMAP_BANK        = 8'hFE;
  localparam logic [7:0]  DUMMY_HI_ADR      = 8'h80;
  // MOS remap stops below this page so I/O and vectors stay on the host
  localparam logic [7:0]  MOS_TOP_EXCL      = 8'hFC;

  // Map and clock control register, bit 6 down to bit 0
  typedef struct packed {
    logic       hsclk_en;
    logic       rom_remap;
    logic       ram_remap;
    logic [1:0] spare;
    logic [1:0] clk_div;
  } map_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/cpu_cycle_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One CPU bus cycle, held from one rising clock edge to the next
interface cpu_cycle_if;

  logic [15:0] adr;
  logic [7:0]  bank;
  logic [7:0]  wdata;
  logic        rnw;
  logic        vda;
  logic        vpa;

  // Driven by the top level from the CPU pins
  modport source (
    output adr, bank, wdata, rnw, vda, vpa
  );

  // Observed by every decode block
  modport sink (
    input adr, bank, wdata, rnw, vda, vpa
  );

endinterface

`default_nettype wire

// ==== hdl/addr_remap.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_remap
  import accel_pkg::*;
(
  cpu_cycle_if.sink              cyc,
  input  map_cfg_t               map_cfg,
  input  logic [PAGEREG_SZ-1:0]  pagereg,
  output logic [7:0]             eff_bank,
  output logic                   himem,
  output logic                   ram_ceb,
  output logic [2:0]             ram_bank
);

  logic cyc_valid;
  logic lo_bank;
  logic mos_range;
  logic basic_range;
  logic rom_hit;
  logic ram_hit;
  logic vram_wr;

  assign cyc_valid = cyc.vda | cyc.vpa;
  assign lo_bank   = ~cyc.bank[7];

  // ------------------------------
  // ROM and RAM remap detection
  // ------------------------------

  // MOS lives at C000 up to the start of the I/O page
  assign mos_range = (cyc.adr[15:14] == 2'b11) && (cyc.adr[15:8] < MOS_TOP_EXCL);

  // Paged ROM window, only remapped while the BASIC slot is selected
  assign basic_range = (cyc.adr[15:14] == 2'b10) && (pagereg == BASIC_ROM_SLOT);

  assign rom_hit = map_cfg.rom_remap & cyc_valid & lo_bank & (mos_range | basic_range);

  // Only the bottom 8K of host RAM is moved on board
  assign ram_hit = map_cfg.ram_remap & cyc_valid & lo_bank & (cyc.adr[15:13] == 3'b000);

  // Remapped accesses land in FE, or FF if the raw bank had bit 0 set
  always_comb
  begin
    eff_bank = cyc.bank;
    if (rom_hit || ram_hit)
    begin
      eff_bank[7:1] = cyc.bank[7:1] | REMAP_BANK[7:1];
    end
  end

  // ------------------------------
  // On-board RAM and himem
  // ------------------------------
  assign ram_ceb  = ~(cyc_valid && (eff_bank[7:6] == RAM_BANK_TAG));
  assign ram_bank = eff_bank[2:0];

  // Host video RAM writes must still reach the host, 2000 to 7FFF in bank 0
  assign vram_wr = cyc.vda & ~cyc.rnw & lo_bank & ~cyc.adr[15] &
                   (cyc.adr[14] | cyc.adr[13]);

  assign himem = eff_bank[7] & ~vram_wr;

endmodule

`default_nettype wire

// ==== hdl/cpld_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpld_regs
  import accel_pkg::*;
(
  input  logic                   cpu_phi2_w,
  input  logic                   resetb,
  cpu_cycle_if.sink              cyc,
  input  logic [7:0]             eff_bank,
  input  logic [7:0]             host_rdata,
  input  logic [GPIO_SZ-1:0]     gpio_in,
  output map_cfg_t               map_cfg,
  output logic [PAGEREG_SZ-1:0]  pagereg,
  output logic [GPIO_SZ-1:0]     gpio_out,
  output logic [GPIO_SZ-1:0]     gpio_oe,
  output logic [7:0]             cpu_rdata,
  output logic                   cpu_rdata_oe
);

  map_cfg_t               map_q;
  logic [GPIO_SZ-1:0]     gpio_data_q;
  logic [GPIO_SZ-1:0]     gpio_dir_q;
  logic [PAGEREG_SZ-1:0]  pagereg_q;

  logic reg_blk;
  logic sel_map;
  logic sel_gpio_data;
  logic sel_gpio_dir;
  logic sel_pagereg;
  logic wr_cycle;
  logic rd_cycle;

  // ------------------------------
  // Register decode
  // ------------------------------
  assign reg_blk       = cyc.vda && (eff_bank[7:6] == REG_BANK_TAG);
  assign sel_map       = reg_blk && (cyc.adr[1:0] == REG_SEL_MAP);
  assign sel_gpio_data = reg_blk && (cyc.adr[1:0] == REG_SEL_GPIO_DATA);
  assign sel_gpio_dir  = reg_blk && (cyc.adr[1:0] == REG_SEL_GPIO_DIR);

  // The host paged ROM register is snooped so the BASIC remap knows the slot
  assign sel_pagereg = cyc.vda && ~cyc.bank[7] && (cyc.adr == PAGED_ROM_SEL_ADR);

  assign wr_cycle = cyc.vda & ~cyc.rnw;
  assign rd_cycle = (cyc.vda | cyc.vpa) & cyc.rnw;

  always_ff @(posedge cpu_phi2_w or negedge resetb)
  begin
    if (!resetb)
    begin
      map_q       <= '0;
      gpio_data_q <= '0;
      gpio_dir_q  <= '0;
      pagereg_q   <= '0;
    end
    else if (wr_cycle)
    begin
      if (sel_map)
        map_q <= map_cfg_t'(cyc.wdata[MAP_CC_DATA_SZ-1:0]);
      if (sel_gpio_data)
        gpio_data_q <= cyc.wdata[GPIO_SZ-1:0];
      if (sel_gpio_dir)
        gpio_dir_q <= cyc.wdata[GPIO_SZ-1:0];
      if (sel_pagereg)
        pagereg_q <= cyc.wdata[PAGEREG_SZ-1:0];
    end
  end

  assign map_cfg = map_q;
  assign pagereg = pagereg_q;

  // A pin is an output only where its direction bit is set
  assign gpio_out = gpio_data_q;
  assign gpio_oe  = gpio_dir_q;

  // ------------------------------
  // CPU read data steering
  // ------------------------------
  always_comb
  begin
    cpu_rdata    = '0;
    cpu_rdata_oe = 1'b0;
    if (rd_cycle)
    begin
      if (!eff_bank[7])
      begin
        cpu_rdata    = host_rdata;
        cpu_rdata_oe = 1'b1;
      end
      else if (sel_map)
      begin
        cpu_rdata    = {{(8-MAP_CC_DATA_SZ){1'b0}}, map_q};
        cpu_rdata_oe = 1'b1;
      end
      else if (sel_gpio_data)
      begin
        // Pin state, not the data register
        cpu_rdata    = {{(8-GPIO_SZ){1'b0}}, gpio_in};
        cpu_rdata_oe = 1'b1;
      end
      else if (sel_gpio_dir)
      begin
        cpu_rdata    = {{(8-GPIO_SZ){1'b0}}, gpio_dir_q};
        cpu_rdata_oe = 1'b1;
      end
      // Everything else in the upper half is served by on-board RAM
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hs_clk_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module hs_clk_select
  import accel_pkg::*;
(
  input  logic        cpu_phi2_w,
  input  logic        resetb,
  cpu_cycle_if.sink   cyc,
  input  map_cfg_t    map_cfg,
  input  logic        himem,
  output logic        dummy_access,
  output logic        hs_active,
  output logic [1:0]  hsclk_div
);

  typedef enum logic [1:0] {
    HS_LOW,
    HS_GAP_TO_HIGH,
    HS_HIGH,
    HS_GAP_TO_LOW
  } hs_state_t;

  hs_state_t state_q;

  logic cyc_valid;
  logic sync_cyc;
  logic hisync;
  logic hisync_q;
  logic hs_selected;
  logic ls_selected;
  logic sel_hs;

  assign cyc_valid   = cyc.vda | cyc.vpa;
  assign sync_cyc    = cyc.vda & cyc.vpa;
  assign hisync      = sync_cyc & himem;
  assign hs_selected = (state_q == HS_HIGH);
  assign ls_selected = (state_q == HS_LOW);

  // Request the fast clock on a second himem opcode fetch, or keep it while
  // the CPU stays in himem or runs idle cycles
  assign sel_hs = map_cfg.hsclk_en & ((hisync & hisync_q) |
                                      (cyc_valid & himem & hs_selected) |
                                      (~cyc_valid & hs_selected));

  // Any cycle that is not on the host clock becomes a dummy host read
  assign dummy_access = himem | sel_hs | ~ls_selected;

  assign hs_active = hs_selected;
  assign hsclk_div = map_cfg.clk_div;

  // ------------------------------
  // Sync tracking and handover
  // ------------------------------
  always_ff @(posedge cpu_phi2_w or negedge resetb)
  begin
    if (!resetb)
    begin
      hisync_q <= 1'b0;
      state_q  <= HS_LOW;
    end
    else
    begin
      // Remember whether the last opcode fetch came from himem
      if (!map_cfg.hsclk_en)
        hisync_q <= 1'b0;
      else if (sync_cyc)
        hisync_q <= hisync;

      // Break before make, one cycle with neither clock between the two
      case (state_q)
        HS_LOW:         if (sel_hs) state_q <= HS_GAP_TO_HIGH;
        HS_GAP_TO_HIGH: state_q <= HS_HIGH;
        HS_HIGH:        if (!sel_hs) state_q <= HS_GAP_TO_LOW;
        default:        state_q <= HS_LOW;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/host_bus_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_bus_bridge
  import accel_pkg::*;
(
  cpu_cycle_if.sink   cyc,
  input  logic        dummy_access,
  output logic [7:0]  host_adr_hi,
  output logic        host_rnw,
  output logic        host_sync,
  output logic [7:0]  host_wdata,
  output logic        host_wdata_oe
);

  // ------------------------------
  // Address and direction
  // ------------------------------

  // A dummy cycle parks the host on a harmless read of the 80xx ROM area
  assign host_adr_hi = dummy_access ? DUMMY_HI_ADR : cyc.adr[15:8];
  assign host_rnw    = cyc.rnw | dummy_access;

  assign host_sync = cyc.vda & cyc.vpa;

  // ------------------------------
  // Write data
  // ------------------------------
  assign host_wdata = cyc.wdata;

  // Only a data write that really goes to the host drives the bus
  assign host_wdata_oe = cyc.vda & ~host_rnw;

endmodule

`default_nettype wire

// ==== hdl/level1b_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module level1b_accel_top
  import accel_pkg::*;
(
  input  logic                cpu_phi2_w,
  input  logic                resetb,
  input  logic [15:0]         cpu_adr,
  input  logic [7:0]          cpu_bank,
  input  logic [7:0]          cpu_wdata,
  input  logic                cpu_rnw,
  input  logic                cpu_vda,
  input  logic                cpu_vpa,
  input  logic [7:0]          host_rdata,
  input  logic [GPIO_SZ-1:0]  gpio_in,
  output logic [7:0]          cpu_rdata,
  output logic                cpu_rdata_oe,
  output logic                ram_ceb,
  output logic [2:0]          ram_bank,
  output logic [7:0]          host_adr_hi,
  output logic                host_rnw,
  output logic                host_sync,
  output logic [7:0]          host_wdata,
  output logic                host_wdata_oe,
  output logic [GPIO_SZ-1:0]  gpio_out,
  output logic [GPIO_SZ-1:0]  gpio_oe,
  output logic                hs_active,
  output logic [1:0]          hsclk_div
);

  cpu_cycle_if cyc ();

  map_cfg_t               map_cfg;
  logic [PAGEREG_SZ-1:0]  pagereg;
  logic [7:0]             eff_bank;
  logic                   himem;
  logic                   dummy_access;

  // CPU pins feed the shared cycle bundle
  assign cyc.adr   = cpu_adr;
  assign cyc.bank  = cpu_bank;
  assign cyc.wdata = cpu_wdata;
  assign cyc.rnw   = cpu_rnw;
  assign cyc.vda   = cpu_vda;
  assign cyc.vpa   = cpu_vpa;

  addr_remap u_addr_remap (
    .cyc      (cyc.sink),
    .map_cfg  (map_cfg),
    .pagereg  (pagereg),
    .eff_bank (eff_bank),
    .himem    (himem),
    .ram_ceb  (ram_ceb),
    .ram_bank (ram_bank)
  );

  cpld_regs u_cpld_regs (
    .cpu_phi2_w   (cpu_phi2_w),
    .resetb       (resetb),
    .cyc          (cyc.sink),
    .eff_bank     (eff_bank),
    .host_rdata   (host_rdata),
    .gpio_in      (gpio_in),
    .map_cfg      (map_cfg),
    .pagereg      (pagereg),
    .gpio_out     (gpio_out),
    .gpio_oe      (gpio_oe),
    .cpu_rdata    (cpu_rdata),
    .cpu_rdata_oe (cpu_rdata_oe)
  );

  hs_clk_select u_hs_clk_select (
    .cpu_phi2_w   (cpu_phi2_w),
    .resetb       (resetb),
    .cyc          (cyc.sink),
    .map_cfg      (map_cfg),
    .himem        (himem),
    .dummy_access (dummy_access),
    .hs_active    (hs_active),
    .hsclk_div    (hsclk_div)
  );

  host_bus_bridge u_host_bus_bridge (
    .cyc           (cyc.sink),
    .dummy_access  (dummy_access),
    .host_adr_hi   (host_adr_hi),
    .host_rnw      (host_rnw),
    .host_sync     (host_sync),
    .host_wdata    (host_wdata),
    .host_wdata_oe (host_wdata_oe)
  );

endmodule

`default_nettype wire

// ==== verif/level1b_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module level1b_assert
  import accel_pkg::*;
(
  input logic       cpu_phi2_w,
  input logic       resetb,
  input logic       cpu_rnw,
  input logic       ram_ceb,
  input logic       host_wdata_oe,
  input logic       cpu_rdata_oe,
  input logic       hs_active,
  input logic [7:0] host_adr_hi
);

  // Number of assertion failures seen so far
  int fail_count = 0;

  // On-board RAM and a host write never share a cycle
  ram_host_exclusive: assert property (@(posedge cpu_phi2_w) disable iff (!resetb)
    !(!ram_ceb && host_wdata_oe))
    else
    begin
      fail_count++;
      $error("ram_ceb and host_wdata_oe active in the same cycle");
    end

  // The gap cycle before the fast clock parks the host on a dummy read
  hs_after_dummy: assert property (@(posedge cpu_phi2_w) disable iff (!resetb)
    $rose(hs_active) |-> $past(host_adr_hi) == DUMMY_HI_ADR)
    else
    begin
      fail_count++;
      $error("hs_active rose without a preceding dummy host cycle");
    end

  no_rdata_on_write: assert property (@(posedge cpu_phi2_w) disable iff (!resetb)
    !cpu_rnw |-> !cpu_rdata_oe)
    else
    begin
      fail_count++;
      $error("cpu_rdata_oe high during a write cycle");
    end

endmodule

bind level1b_accel_top level1b_assert u_level1b_assert (
  .cpu_phi2_w    (cpu_phi2_w),
  .resetb        (resetb),
  .cpu_rnw       (cpu_rnw),
  .ram_ceb       (ram_ceb),
  .host_wdata_oe (host_wdata_oe),
  .cpu_rdata_oe  (cpu_rdata_oe),
  .hs_active     (hs_active),
  .host_adr_hi   (host_adr_hi)
);

`default_nettype wire

// ==== verif/level1b_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module level1b_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  // Upper bound on the bus cycles used by all tests together
  localparam int TEST_CYCLES  = 300;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD + 400;

  logic        cpu_phi2_w;
  logic        resetb;
  logic [15:0] cpu_adr;
  logic [7:0]  cpu_bank;
  logic [7:0]  cpu_wdata;
  logic        cpu_rnw;
  logic        cpu_vda;
  logic        cpu_vpa;
  logic [7:0]  host_rdata;
  logic [1:0]  gpio_in;
  logic [7:0]  cpu_rdata;
  logic        cpu_rdata_oe;
  logic        ram_ceb;
  logic [2:0]  ram_bank;
  logic [7:0]  host_adr_hi;
  logic        host_rnw;
  logic        host_sync;
  logic [7:0]  host_wdata;
  logic        host_wdata_oe;
  logic [1:0]  gpio_out;
  logic [1:0]  gpio_oe;
  logic        hs_active;
  logic [1:0]  hsclk_div;

  // Expected response of one bus cycle
  typedef struct packed {
    logic       rdata_oe;
    logic [7:0] rdata;
    logic       ceb;
    logic [2:0] rbank;
    logic [7:0] adr_hi;
    logic       rnw;
    logic       wdata_oe;
    logic       himem;
    logic       req;
    logic       reg_hit;
  } exp_t;

  // Reference state. Map bits are 6 hsclk_en, 5 rom_remap, 4 ram_remap, 1:0 clk_div
  logic [6:0] ref_map;
  logic [3:0] ref_page;
  logic [1:0] ref_gdata;
  logic [1:0] ref_gdir;
  // Handover phase 0 low, 1 gap to high, 2 high, 3 gap to low
  logic [1:0] ref_hs;
  logic       ref_hisync;
  exp_t       exp_q;
  integer     seed;

  level1b_accel_top DUT (
    .cpu_phi2_w    (cpu_phi2_w),
    .resetb        (resetb),
    .cpu_adr       (cpu_adr),
    .cpu_bank      (cpu_bank),
    .cpu_wdata     (cpu_wdata),
    .cpu_rnw       (cpu_rnw),
    .cpu_vda       (cpu_vda),
    .cpu_vpa       (cpu_vpa),
    .host_rdata    (host_rdata),
    .gpio_in       (gpio_in),
    .cpu_rdata     (cpu_rdata),
    .cpu_rdata_oe  (cpu_rdata_oe),
    .ram_ceb       (ram_ceb),
    .ram_bank      (ram_bank),
    .host_adr_hi   (host_adr_hi),
    .host_rnw      (host_rnw),
    .host_sync     (host_sync),
    .host_wdata    (host_wdata),
    .host_wdata_oe (host_wdata_oe),
    .gpio_out      (gpio_out),
    .gpio_oe       (gpio_oe),
    .hs_active     (hs_active),
    .hsclk_div     (hsclk_div)
  );

  initial
  begin
    cpu_phi2_w = 1'b0;
    forever #(CLK_PERIOD / 2) cpu_phi2_w = ~cpu_phi2_w;
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic exp_t expect_cycle(input logic [7:0] bank, input logic [15:0] adr,
                                        input logic rnw, input logic vda, input logic vpa,
                                        input logic [7:0] hrdata, input logic [1:0] gpin);
    exp_t       e;
    logic       valid;
    logic       remap;
    logic       dummy;
    logic [7:0] eb;
    valid = vda | vpa;
    remap = 1'b0;
    if (valid && !bank[7])
    begin
      // MOS ROM below the I/O page, BASIC in the paged window, then the bottom 8K of RAM
      if (ref_map[5] && adr >= 16'hC000 && adr < 16'hFC00)
        remap = 1'b1;
      if (ref_map[5] && adr >= 16'h8000 && adr < 16'hC000 && ref_page == 4'hF)
        remap = 1'b1;
      if (ref_map[4] && adr < 16'h2000)
        remap = 1'b1;
    end
    eb = remap ? {7'h7F, bank[0]} : bank;
    e = '0;
    e.ceb   = !(valid && eb >= 8'hC0);
    e.rbank = eb[2:0];
    e.himem = eb[7] && !(vda && !rnw && !bank[7] && adr >= 16'h2000 && adr < 16'h8000);
    e.req   = ref_map[6] && ((vda && vpa && e.himem && ref_hisync) ||
                             (valid && e.himem && ref_hs == 2'd2) ||
                             (!valid && ref_hs == 2'd2));
    dummy      = e.himem || e.req || ref_hs != 2'd0;
    e.adr_hi   = dummy ? 8'h80 : adr[15:8];
    e.rnw      = rnw || dummy;
    e.wdata_oe = vda && !e.rnw;
    e.reg_hit  = vda && eb[7:6] == 2'b10;
    if (valid && rnw)
    begin
      if (!eb[7])
      begin
        e.rdata_oe = 1'b1;
        e.rdata    = hrdata;
      end
      else if (e.reg_hit && adr[1:0] != 2'd2)
      begin
        e.rdata_oe = 1'b1;
        case (adr[1:0])
          2'd3:    e.rdata = {1'b0, ref_map};
          2'd1:    e.rdata = {6'b0, gpin};
          default: e.rdata = {6'b0, ref_gdir};
        endcase
      end
    end
    return e;
  endfunction

  // Registered state moves on at the edge that ends the cycle
  task automatic advance_model(input exp_t e);
    if (!ref_map[6])
      ref_hisync = 1'b0;
    else if (cpu_vda && cpu_vpa)
      ref_hisync = e.himem;
    case (ref_hs)
      2'd0:
        if (e.req)
          ref_hs = 2'd1;
      2'd1:
        ref_hs = 2'd2;
      2'd2:
        if (!e.req)
          ref_hs = 2'd3;
      default:
        ref_hs = 2'd0;
    endcase
    if (cpu_vda && !cpu_rnw)
    begin
      if (e.reg_hit && cpu_adr[1:0] == 2'd3)
        ref_map = cpu_wdata[6:0];
      if (e.reg_hit && cpu_adr[1:0] == 2'd1)
        ref_gdata = cpu_wdata[1:0];
      if (e.reg_hit && cpu_adr[1:0] == 2'd0)
        ref_gdir = cpu_wdata[1:0];
      if (!cpu_bank[7] && cpu_adr == 16'hFE30)
        ref_page = cpu_wdata[3:0];
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic drive_cycle(input logic [7:0] bank, input logic [15:0] adr,
                             input logic rnw, input logic vda, input logic vpa,
                             input logic [7:0] wdata);
    @(posedge cpu_phi2_w);
    cpu_bank   <= bank;
    cpu_adr    <= adr;
    cpu_rnw    <= rnw;
    cpu_vda    <= vda;
    cpu_vpa    <= vpa;
    cpu_wdata  <= wdata;
    host_rdata <= $random(seed);
    gpio_in    <= $random(seed);
  endtask

  task automatic read_cycle(input logic [7:0] bank, input logic [15:0] adr);
    drive_cycle(bank, adr, 1'b1, 1'b1, 1'b0, $random(seed));
  endtask

  task automatic write_cycle(input logic [7:0] bank, input logic [15:0] adr,
                             input logic [7:0] data);
    drive_cycle(bank, adr, 1'b0, 1'b1, 1'b0, data);
  endtask

  task automatic fetch_opcode(input logic [7:0] bank, input logic [15:0] adr);
    drive_cycle(bank, adr, 1'b1, 1'b1, 1'b1, $random(seed));
  endtask

  task automatic idle_cycle();
    drive_cycle(cpu_bank, cpu_adr, 1'b1, 1'b0, 1'b0, 8'h00);
  endtask

  // Compare at the falling edge, half way through each cycle
  always @(negedge cpu_phi2_w)
  begin
    if (resetb)
    begin
      exp_q = expect_cycle(cpu_bank, cpu_adr, cpu_rnw, cpu_vda, cpu_vpa, host_rdata, gpio_in);
      check_value("cpu_rdata_oe", cpu_rdata_oe, exp_q.rdata_oe);
      if (exp_q.rdata_oe)
        check_value("cpu_rdata", cpu_rdata, exp_q.rdata);
      check_value("ram_ceb", ram_ceb, exp_q.ceb);
      check_value("ram_bank", ram_bank, exp_q.rbank);
      check_value("host_adr_hi", host_adr_hi, exp_q.adr_hi);
      check_value("host_rnw", host_rnw, exp_q.rnw);
      check_value("host_sync", host_sync, cpu_vda & cpu_vpa);
      check_value("host_wdata_oe", host_wdata_oe, exp_q.wdata_oe);
      if (exp_q.wdata_oe)
        check_value("host_wdata", host_wdata, cpu_wdata);
      check_value("gpio_out", gpio_out, ref_gdata);
      check_value("gpio_oe", gpio_oe, ref_gdir);
      check_value("hs_active", hs_active, ref_hs == 2'd2);
      check_value("hsclk_div", hsclk_div, ref_map[1:0]);
      check_value("assertion failures", DUT.u_level1b_assert.fail_count, 0);
      advance_model(exp_q);
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    logic [7:0] rand_bank;
    logic       rand_rnw;
    seed       = 76;
    resetb     = 1'b0;
    cpu_adr    = '0;
    cpu_bank   = '0;
    cpu_wdata  = '0;
    cpu_rnw    = 1'b1;
    cpu_vda    = 1'b0;
    cpu_vpa    = 1'b0;
    host_rdata = '0;
    gpio_in    = '0;
    ref_map    = '0;
    ref_page   = '0;
    ref_gdata  = '0;
    ref_gdir   = '0;
    ref_hs     = 2'd0;
    ref_hisync = 1'b0;
    repeat (RESET_CYCLES) @(posedge cpu_phi2_w);
    resetb <= 1'b1;

    // Random traffic with the map cleared, no writes into the register bank
    for (int i = 0; i < 200; i++)
    begin
      rand_bank = $random(seed);
      rand_rnw  = $random(seed);
      if (rand_bank[7:6] == 2'b10)
        rand_rnw = 1'b1;
      drive_cycle(rand_bank, $random(seed), rand_rnw, $random(seed), $random(seed),
                  $random(seed));
    end

    // Register writes and read back, only bank bits 7:6 and adr 1:0 decode
    write_cycle(8'h80, 16'h0003, 8'h8F);
    write_cycle(8'hA5, 16'h1230, 8'hFE);
    write_cycle(8'hBF, 16'h4561, 8'hFD);
    read_cycle(8'h80, 16'h0003);
    read_cycle(8'h80, 16'h0000);
    read_cycle(8'h9C, 16'h7771);
    read_cycle(8'h80, 16'h0002);
    write_cycle(8'h80, 16'h0000, 8'h03);
    read_cycle(8'h80, 16'h0001);

    // ROM and RAM remap
    write_cycle(8'h80, 16'h0003, 8'h30);
    read_cycle(8'h00, 16'hC000);
    read_cycle(8'h00, 16'hE123);
    read_cycle(8'h00, 16'hFBFF);
    read_cycle(8'h00, 16'hFC00);
    read_cycle(8'h00, 16'hFFFC);
    read_cycle(8'h00, 16'h8000);
    write_cycle(8'h00, 16'hFE30, 8'h0F);
    read_cycle(8'h00, 16'h8000);
    read_cycle(8'h00, 16'hBFFF);
    fetch_opcode(8'h00, 16'hA123);
    read_cycle(8'h01, 16'hC100);
    write_cycle(8'h00, 16'hFE30, 8'h03);
    read_cycle(8'h00, 16'h9000);
    read_cycle(8'h00, 16'h0000);
    read_cycle(8'h00, 16'h1FFF);
    read_cycle(8'h00, 16'h2000);
    write_cycle(8'h00, 16'h1000, 8'h55);
    write_cycle(8'h00, 16'h3000, 8'hAA);

    // Read steering with the map cleared again
    write_cycle(8'h80, 16'h0003, 8'h00);
    read_cycle(8'h80, 16'h0006);
    for (int j = 0; j < 4; j++)
    begin
      read_cycle(8'hC0 | 8'($random(seed)), $random(seed));
      read_cycle(8'h7F & 8'($random(seed)), $random(seed));
    end

    // Handover to the fast clock and back
    write_cycle(8'h80, 16'h0003, 8'h41);
    fetch_opcode(8'h00, 16'h0400);
    fetch_opcode(8'h00, 16'h0401);
    fetch_opcode(8'h80, 16'h1000);
    fetch_opcode(8'h80, 16'h1001);
    idle_cycle();
    fetch_opcode(8'h80, 16'h1002);
    read_cycle(8'h80, 16'h2005);
    write_cycle(8'hC0, 16'h1234, 8'h5A);
    idle_cycle();
    for (int k = 0; k < 4; k++)
      fetch_opcode(8'h00, 16'h0402 + k);
    write_cycle(8'h80, 16'h0003, 8'h00);
    idle_cycle();

    // Let the assertions see the last edge before the final verdict
    @(posedge cpu_phi2_w);
    @(negedge cpu_phi2_w);
    check_value("assertion failures", DUT.u_level1b_assert.fail_count, 0);
    $display("All tests passed!");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Test failures found");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/accel_pkg.sv
hdl/cpu_cycle_if.sv
hdl/addr_remap.sv
hdl/cpld_regs.sv
hdl/hs_clk_select.sv
hdl/host_bus_bridge.sv
hdl/level1b_accel_top.sv
verif/level1b_assert.sv
verif/level1b_tb.sv

// ==== Bender.yml ====
package:
  name: level1b_accel

sources:
  - files:
      - hdl/accel_pkg.sv
      - hdl/cpu_cycle_if.sv
      - hdl/addr_remap.sv
      - hdl/cpld_regs.sv
      - hdl/hs_clk_select.sv
      - hdl/host_bus_bridge.sv
      - hdl/level1b_accel_top.sv
  - target: test
    files:
      - verif/level1b_assert.sv
      - verif/level1b_tb.sv
